// ==== hdl/mask_pkg.sv ====
// filter mask loader shared definitions
// word layout, register group counts and size code decoding constants
package mask_pkg;

	// ************************************************************
	// memory word layout
	// ************************************************************

	// one mask coefficient
	localparam int ELEM_W = 10;
	// memory controller data width
	localparam int WORD_W = 32;
	// coefficients packed in bits 9:0, 19:10 and 29:20, top two bits unused
	localparam int ELEMS_PER_WORD = 3;
	// byte step between consecutive words
	localparam int WORD_BYTES = 4;

	// ************************************************************
	// coefficient storage
	// ************************************************************

	// one group per memory word, enough for a 5x5 mask
	localparam int MAX_GROUPS = 9;
	localparam int COEF_COUNT = MAX_GROUPS * ELEMS_PER_WORD;
	// index into the stored coefficients, 27 fits in 5 bits
	localparam int COEF_IDX_W = 5;

	// ************************************************************
	// size codes and words read per size
	// ************************************************************

	// counts up to MAX_GROUPS words
	localparam int WORD_CNT_W = 4;
	localparam int SIZE_W = 3;

	localparam logic [SIZE_W-1:0] SIZE_3X3 = 3'd3;
	localparam logic [SIZE_W-1:0] SIZE_5X5 = 3'd5;

	// size squared over three, rounded up
	localparam logic [WORD_CNT_W-1:0] WORDS_3X3 = 4'd3;
	localparam logic [WORD_CNT_W-1:0] WORDS_5X5 = 4'd9;
	// unknown size code, a single word like the old default
	localparam logic [WORD_CNT_W-1:0] WORDS_OTHER = 4'd1;

endpackage

// ==== hdl/mask_read_seq.sv ====
// mask read sequencer
// issues one word read at a time, counts completions and walks the group pointer
module mask_read_seq #(
	parameter int ADDR_W = 10
) (
	input  logic                             clk,
	input  logic                             reset,
	// load request from the mask control
	input  logic                             start,
	input  logic [mask_pkg::SIZE_W-1:0]      mask_size,
	input  logic [ADDR_W-1:0]                base_addr,
	// memory controller side
	input  logic                             rd_done,
	output logic                             rd_req,
	output logic [ADDR_W-1:0]                rd_addr,
	// coefficient group write control
	output logic [mask_pkg::MAX_GROUPS-1:0]  group_sel,
	output logic                             word_wr,
	// whole mask held in the groups
	output logic                             mask_valid
);

	// state encoding
	localparam logic [2:0] ST_IDLE   = 3'd0;
	localparam logic [2:0] ST_READ   = 3'd1;
	localparam logic [2:0] ST_WAIT   = 3'd2;
	localparam logic [2:0] ST_CHECK  = 3'd3;
	localparam logic [2:0] ST_LOADED = 3'd4;

	logic [2:0] state;
	logic [2:0] state_next;

	// start only counts when no load is running
	logic start_ok;

	// words wanted for the latched size and words received so far
	logic [mask_pkg::WORD_CNT_W-1:0] word_target;
	logic [mask_pkg::WORD_CNT_W-1:0] target_next;
	logic [mask_pkg::WORD_CNT_W-1:0] word_cnt;

	// last word of the mask received
	logic all_read;

	// ************************************************************
	// control decode
	// ************************************************************

	assign start_ok = start && ((state == ST_IDLE) || (state == ST_LOADED));

	// capture only while the read is outstanding
	assign word_wr = rd_done && (state == ST_WAIT);

	assign all_read = (word_cnt == word_target);

	// words per size code
	always_comb begin
		case (mask_size)
			mask_pkg::SIZE_3X3: target_next = mask_pkg::WORDS_3X3;
			mask_pkg::SIZE_5X5: target_next = mask_pkg::WORDS_5X5;
			default:            target_next = mask_pkg::WORDS_OTHER;
		endcase
	end

	// ************************************************************
	// state machine
	// ************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (start_ok) begin
					state_next = ST_READ;
				end
			end
			// request lasts a single cycle
			ST_READ: begin
				state_next = ST_WAIT;
			end
			// no timeout, the controller may take as long as it needs
			ST_WAIT: begin
				if (rd_done) begin
					state_next = ST_CHECK;
				end
			end
			ST_CHECK: begin
				if (all_read) begin
					state_next = ST_LOADED;
				end else begin
					state_next = ST_READ;
				end
			end
			// mask stays valid until a reload
			ST_LOADED: begin
				if (start_ok) begin
					state_next = ST_READ;
				end
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	// ************************************************************
	// address, word counter and group pointer
	// ************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_addr     <= '0;
			word_target <= '0;
			word_cnt    <= '0;
			group_sel   <= mask_pkg::MAX_GROUPS'(1);
		end else if (start_ok) begin
			// new load restarts everything from group 0
			rd_addr     <= base_addr;
			word_target <= target_next;
			word_cnt    <= '0;
			group_sel   <= mask_pkg::MAX_GROUPS'(1);
		end else begin
			if (word_wr) begin
				word_cnt <= word_cnt + 1'b1;
			end
			// step to the next word once the current one is stored
			if (state == ST_CHECK) begin
				rd_addr   <= rd_addr + ADDR_W'(mask_pkg::WORD_BYTES);
				group_sel <= group_sel << 1;
			end
		end
	end

	// moore outputs
	assign rd_req     = (state == ST_READ);
	assign mask_valid = (state == ST_LOADED);

endmodule

// ==== hdl/mask_group.sv ====
// one coefficient register group
// splits a memory word into three coefficients and holds them
module mask_group (
	input  logic                            clk,
	input  logic                            reset,
	// write strobe for this group only
	input  logic                            wr,
	input  logic [mask_pkg::WORD_W-1:0]     word,
	// slot 0 comes from the low bits of the word
	output logic [mask_pkg::ELEMS_PER_WORD-1:0][mask_pkg::ELEM_W-1:0] elems
);

	// ************************************************************
	// coefficient registers
	// ************************************************************

	// fixed slices 9:0, 19:10 and 29:20
	// bits above the last slice are ignored
	always_ff @(posedge clk) begin
		if (reset) begin
			elems <= '0;
		end else if (wr) begin
			for (int i = 0; i < mask_pkg::ELEMS_PER_WORD; i++) begin
				elems[i] <= word[i*mask_pkg::ELEM_W +: mask_pkg::ELEM_W];
			end
		end
	end

	// without wr the group keeps its last load

endmodule

// ==== hdl/coef_select.sv ====
// coefficient selector
// registered indexed read of the stored mask, one tap per cycle
module coef_select (
	input  logic                                clk,
	input  logic                                reset,
	// index presented by the filter datapath
	input  logic [mask_pkg::COEF_IDX_W-1:0]     coef_index,
	// every stored coefficient, entry k from group k/3 slot k mod 3
	input  logic [mask_pkg::COEF_COUNT-1:0][mask_pkg::ELEM_W-1:0] coefs,
	// value one cycle after the index
	output logic [mask_pkg::ELEM_W-1:0]         coef_value
);

	// index points at a real register
	logic in_range;

	// selected coefficient before the output register
	logic [mask_pkg::ELEM_W-1:0] coef_mux;

	// ************************************************************
	// read mux
	// ************************************************************

	assign in_range = (coef_index < mask_pkg::COEF_COUNT);

	// indices past the last register read as zero
	always_comb begin
		if (in_range) begin
			coef_mux = coefs[coef_index];
		end else begin
			coef_mux = '0;
		end
	end

	// ************************************************************
	// output register
	// ************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			coef_value <= '0;
		end else begin
			coef_value <= coef_mux;
		end
	end

endmodule

// ==== hdl/mask_loader.sv ====
// filter mask loader top level
// reads mask words from memory into register groups, exposes them by index
module mask_loader #(
	parameter int ADDR_W = 10
) (
	input  logic                             clk,
	input  logic                             reset,
	// load request
	input  logic                             start,
	input  logic [mask_pkg::SIZE_W-1:0]      mask_size,
	input  logic [ADDR_W-1:0]                base_addr,
	// memory controller
	input  logic                             rd_done,
	input  logic [mask_pkg::WORD_W-1:0]      rd_data,
	output logic                             rd_req,
	output logic [ADDR_W-1:0]                rd_addr,
	// mask status and tap read port
	output logic                             mask_valid,
	input  logic [mask_pkg::COEF_IDX_W-1:0]  coef_index,
	output logic [mask_pkg::ELEM_W-1:0]      coef_value
);

	// one-hot group pointer from the sequencer
	logic [mask_pkg::MAX_GROUPS-1:0] group_sel;

	// word accepted this cycle
	logic word_wr;

	// all groups side by side, coefficient k at index k
	logic [mask_pkg::COEF_COUNT-1:0][mask_pkg::ELEM_W-1:0] coefs;

	// ************************************************************
	// read sequencer
	// ************************************************************

	mask_read_seq #(
		.ADDR_W(ADDR_W)
	) read_seq (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.mask_size (mask_size),
		.base_addr (base_addr),
		.rd_done   (rd_done),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.group_sel (group_sel),
		.word_wr   (word_wr),
		.mask_valid(mask_valid)
	);

	// ************************************************************
	// coefficient groups
	// ************************************************************

	for (genvar g = 0; g < mask_pkg::MAX_GROUPS; g++) begin : gen_group
		// this group takes the word when the pointer is on it
		logic group_wr;

		assign group_wr = word_wr & group_sel[g];

		mask_group group (
			.clk  (clk),
			.reset(reset),
			.wr   (group_wr),
			.word (rd_data),
			.elems(coefs[g*mask_pkg::ELEMS_PER_WORD +: mask_pkg::ELEMS_PER_WORD])
		);
	end

	// ************************************************************
	// tap read port
	// ************************************************************

	coef_select select (
		.clk       (clk),
		.reset     (reset),
		.coef_index(coef_index),
		.coefs     (coefs),
		.coef_value(coef_value)
	);

endmodule

// ==== bench/clock_gen.sv ====
// testbench clock and reset source
// free running clock, reset held high for a fixed number of cycles
module clock_gen #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	// release on a rising edge like any other synchronous input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== bench/mem_model.sv ====
// memory controller model
// answers one word read at a time after a random latency, logs every address
module mem_model #(
	parameter int ADDR_W = 10
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        rd_req,
	input  logic [ADDR_W-1:0]           rd_addr,
	output logic                        rd_done,
	output logic [mask_pkg::WORD_W-1:0] rd_data,
	// number of requests seen so far
	output int                          req_count,
	// sticky flag for a byte address off a word boundary
	output logic                        addr_fault
);

	localparam int DEPTH = 256;
	// extra wait cycles before rd_done, 0 to 5
	localparam int MAX_EXTRA = 5;

	// word contents, read by the testbench to build expected values
	logic [mask_pkg::WORD_W-1:0] mem_words [DEPTH];

	// every requested byte address in order
	logic [ADDR_W-1:0] req_log [$];

	int seed;
	int extra;
	logic [ADDR_W-1:0] req_addr;

	initial begin
		seed       = 32'hebc3_479f;
		rd_done    = 1'b0;
		rd_data    = '0;
		req_count  = 0;
		addr_fault = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			mem_words[i] = $random(seed);
		end
		forever begin
			@(posedge clk);
			if (rd_req && !reset) begin
				// address is held by the sequencer until the check state
				req_addr = rd_addr;
				req_log.push_back(req_addr);
				req_count = req_count + 1;
				if (req_addr % mask_pkg::WORD_BYTES != 0) begin
					addr_fault = 1'b1;
				end
				extra = $unsigned($random(seed)) % (MAX_EXTRA + 1);
				repeat (extra) @(posedge clk);
				// data valid in the same cycle as the done pulse
				rd_done <= 1'b1;
				rd_data <= mem_words[req_addr / mask_pkg::WORD_BYTES];
				@(posedge clk);
				rd_done <= 1'b0;
			end
		end
	end

endmodule

// ==== bench/mask_loader_tb.sv ====
// filter mask loader testbench
// directed loads of several mask sizes against a memory model, tap reads by index
module mask_loader_tb;

	localparam int ADDR_W = 10;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 20;

	// ************************************************************
	// run length budget
	// ************************************************************

	// read, wait with up to 5 extra cycles, check
	localparam int WORD_CYCLES = 8;
	// start pulse, drop check and settling per load
	localparam int LOAD_OVERHEAD = 8;
	// 32 indices plus one cycle of read latency
	localparam int SWEEP_CYCLES = 33;
	// after reset, after each of the first three loads and at the end
	localparam int SWEEP_COUNT = 5;
	localparam int LOAD_COUNT = 4;
	// 3x3, 5x5, 3x3 again, other size
	localparam int TOTAL_WORDS = 3 + 9 + 3 + 1;
	localparam int WORST_CYCLES = RESET_CYCLES + IDLE_CYCLES + SWEEP_COUNT * SWEEP_CYCLES
		+ LOAD_COUNT * LOAD_OVERHEAD + TOTAL_WORDS * WORD_CYCLES;

	logic clk;
	logic reset;
	logic start;
	logic [mask_pkg::SIZE_W-1:0] mask_size;
	logic [ADDR_W-1:0] base_addr;
	logic rd_done;
	logic [mask_pkg::WORD_W-1:0] rd_data;
	logic rd_req;
	logic [ADDR_W-1:0] rd_addr;
	logic mask_valid;
	logic [mask_pkg::COEF_IDX_W-1:0] coef_index;
	logic [mask_pkg::ELEM_W-1:0] coef_value;
	int req_count;
	logic addr_fault;

	// expected contents for every index
	// entries 27 to 31 stay zero
	logic [mask_pkg::ELEM_W-1:0] exp_coef [32];

	clock_gen #(
		.PERIOD      (10),
		.RESET_CYCLES(RESET_CYCLES)
	) clkgen (
		.clk  (clk),
		.reset(reset)
	);

	mask_loader #(
		.ADDR_W(ADDR_W)
	) UUT (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.mask_size (mask_size),
		.base_addr (base_addr),
		.rd_done   (rd_done),
		.rd_data   (rd_data),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.mask_valid(mask_valid),
		.coef_index(coef_index),
		.coef_value(coef_value)
	);

	mem_model #(
		.ADDR_W(ADDR_W)
	) mem (
		.clk       (clk),
		.reset     (reset),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rd_done   (rd_done),
		.rd_data   (rd_data),
		.req_count (req_count),
		.addr_fault(addr_fault)
	);

	// ************************************************************
	// checking helpers
	// ************************************************************

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at time %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation stopped");
		end
	endtask

	// size squared over three rounded up
	// unknown codes take one word
	function automatic int words_for_size(input logic [mask_pkg::SIZE_W-1:0] size);
		int s;
		s = size;
		if (s == 3 || s == 5) begin
			return (s * s + 2) / 3;
		end else begin
			return 1;
		end
	endfunction

	// ************************************************************
	// stimulus tasks
	// ************************************************************

	// one index per cycle with each value checked one cycle later
	task automatic sweep_coefs();
		for (int i = 0; i <= 32; i++) begin
			@(posedge clk);
			if (i < 32) begin
				coef_index <= i[mask_pkg::COEF_IDX_W-1:0];
			end
			@(negedge clk);
			if (i > 0) begin
				check_value($sformatf("coef_value[%0d]", i - 1), coef_value, exp_coef[i - 1]);
			end
		end
	endtask

	// start a load, wait for mask_valid and check the request stream
	task automatic run_load(input logic [mask_pkg::SIZE_W-1:0] size, input int base);
		int words;
		int bound;
		int first_req;
		int cycles;
		int last_done;
		logic [mask_pkg::WORD_W-1:0] w;
		words = words_for_size(size);
		bound = words * WORD_CYCLES + 4;
		first_req = req_count;
		@(posedge clk);
		start <= 1'b1;
		mask_size <= size;
		base_addr <= ADDR_W'(base);
		@(posedge clk);
		start <= 1'b0;
		// valid is gone in the cycle after start
		@(negedge clk);
		check_value("mask_valid", mask_valid, 0);
		// first request follows start by one cycle
		check_value("rd_req", rd_req, 1);
		cycles = 0;
		last_done = 0;
		while (!mask_valid) begin
			if (rd_done) begin
				last_done = cycles;
			end
			@(negedge clk);
			cycles++;
			if (cycles > bound) begin
				abort_run($sformatf("load of size %0d at base %0d did not finish in %0d cycles",
					size, base, bound));
			end
		end
		// valid two cycles after the last completion
		check_value("cycles from last rd_done to mask_valid", cycles - last_done, 2);
		check_value("read request count", req_count - first_req, words);
		for (int i = 0; i < words; i++) begin
			check_value($sformatf("rd_addr of request %0d", i), mem.req_log[first_req + i],
				base + i * mask_pkg::WORD_BYTES);
		end
		// coefficient k from word base/4 + k/3, slot k mod 3
		for (int k = 0; k < words * mask_pkg::ELEMS_PER_WORD; k++) begin
			w = mem.mem_words[base / mask_pkg::WORD_BYTES + k / mask_pkg::ELEMS_PER_WORD];
			exp_coef[k] = w[mask_pkg::ELEM_W * (k % mask_pkg::ELEMS_PER_WORD) +: mask_pkg::ELEM_W];
		end
	endtask

	// ************************************************************
	// test sequence
	// ************************************************************

	initial begin
		start = 1'b0;
		mask_size = '0;
		base_addr = '0;
		coef_index = '0;
		for (int i = 0; i < 32; i++) begin
			exp_coef[i] = '0;
		end
		@(negedge clk);
		while (reset) begin
			@(negedge clk);
		end

		// reset state and no traffic while idle
		check_value("mask_valid", mask_valid, 0);
		check_value("rd_addr", rd_addr, 0);
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_value("rd_req", rd_req, 0);
		end
		sweep_coefs();

		// 3x3 from byte 40
		run_load(mask_pkg::SIZE_3X3, 40);
		sweep_coefs();

		// 5x5 from byte 100 with latency varying per word
		run_load(mask_pkg::SIZE_5X5, 100);
		sweep_coefs();
		check_value("mask_valid", mask_valid, 1);

		// reload over a valid mask
		// groups 3 to 8 keep the 5x5 words
		run_load(mask_pkg::SIZE_3X3, 200);
		sweep_coefs();

		// unknown code reads one word into group 0
		run_load(3'd6, 300);

		// final sweep covers latency and the out of range indices
		sweep_coefs();
		check_value("mask_valid", mask_valid, 1);

		$display("TEST RESULT: PASS");
		$finish;
	end

	always @(negedge clk) begin
		if (addr_fault) begin
			abort_run("memory model saw a read address that is not word aligned");
		end
	end

	initial begin
		repeat (2 * WORST_CYCLES) @(posedge clk);
		abort_run($sformatf("watchdog expired after %0d cycles, tests did not finish",
			2 * WORST_CYCLES));
	end

endmodule

// ==== tb.f ====
hdl/mask_pkg.sv
hdl/mask_read_seq.sv
hdl/mask_group.sv
hdl/coef_select.sv
hdl/mask_loader.sv
bench/clock_gen.sv
bench/mem_model.sv
bench/mask_loader_tb.sv

// ==== Bender.yml ====
package:
  name: mask_loader

sources:
  # design, package first
  - hdl/mask_pkg.sv
  - hdl/mask_read_seq.sv
  - hdl/mask_group.sv
  - hdl/coef_select.sv
  - hdl/mask_loader.sv

  # testbench, top module mask_loader_tb
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/mem_model.sv
      - bench/mask_loader_tb.sv
